// File: src/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// width of a data or address word
`define WORD_W 32

// register file addressing
// five index bits reach all 32 registers
`define REG_ADDR_W 5
`define REG_COUNT 32

// data memory depth in words
// byte addresses map onto word entries, upper bits wrap
`define DMEM_WORDS 256

`endif

// File: src/cpu_types_pkg.sv
`include "cpu_consts.svh"

package cpu_types_pkg;

	// basic datapath words
	typedef logic [`WORD_W-1:0] word_t;
	typedef logic [`REG_ADDR_W-1:0] regbits_t;

	// primary opcode field, bits 31:26 of the instruction
	typedef enum logic [5:0] {
		RTYPE = 6'b000000,
		J     = 6'b000010,
		BEQ   = 6'b000100,
		ADDI  = 6'b001000,
		ORI   = 6'b001101,
		LUI   = 6'b001111,
		LW    = 6'b100011,
		SW    = 6'b101011,
		HALT  = 6'b111111
	} opcode_t;

	// function field of r-type instructions, bits 5:0
	typedef enum logic [5:0] {
		JR   = 6'b001000,
		ADD  = 6'b100000,
		ADDU = 6'b100001,
		SUB  = 6'b100010,
		AND  = 6'b100100,
		OR   = 6'b100101,
		SLT  = 6'b101010
	} funct_t;

endpackage

// File: src/datapath_mux_pkg.sv
package datapath_mux_pkg;

	import cpu_types_pkg::*;

	// which instruction field names the write register
	typedef enum logic [1:0] {
		SEL_RD = 2'd0,
		SEL_RT = 2'd1,
		// link register for jal
		SEL_RA = 2'd2
	} reg_dest_sel_t;

	// source of the write-back data
	typedef enum logic [1:0] {
		SEL_RESULT  = 2'd0,
		SEL_MEMDATA = 2'd1,
		SEL_NPC     = 2'd2
	} mem_to_reg_sel_t;

	// fields a cpu tracker follows down the pipe
	typedef struct packed {
		word_t pc;
		word_t next_pc;
		word_t instruction;
		opcode_t opcode;
		funct_t funct;
	} trace_t;

	// bundle leaving the execute stage
	typedef struct packed {
		logic wen;
		logic mem_read;
		logic mem_write;
		logic halt;
		reg_dest_sel_t reg_dest;
		mem_to_reg_sel_t mem_to_reg;
		word_t result;
		word_t store_data;
		regbits_t rt;
		regbits_t rd;
		trace_t trace;
	} ex_mem_t;

	// contents of the MEM/WB stage register
	typedef struct packed {
		logic wen;
		logic halt;
		reg_dest_sel_t reg_dest;
		mem_to_reg_sel_t mem_to_reg;
		word_t result;
		word_t mem_data;
		regbits_t rt;
		regbits_t rd;
		trace_t trace;
	} mem_wb_t;

endpackage

// File: src/data_mem.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module data_mem (
	input logic CLK,
	input logic nRST,
	input cpu_types_pkg::word_t addr,
	input cpu_types_pkg::word_t store_data,
	input logic mem_write,
	output cpu_types_pkg::word_t load_data
);
	import cpu_types_pkg::*;

	localparam int IDX_W = $clog2(`DMEM_WORDS);
	// two low address bits select a byte within the word
	localparam int BYTE_OFF = 2;

	word_t mem [`DMEM_WORDS];
	logic [IDX_W-1:0] word_idx;

	// word index, anything above the depth is ignored so addresses wrap
	assign word_idx = addr[BYTE_OFF +: IDX_W];

	// asynchronous read, load data is ready in the same cycle
	assign load_data = mem[word_idx];

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < `DMEM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (mem_write) begin
			// a stalled store writes the same word again
			mem[word_idx] <= store_data;
		end
	end

endmodule

// File: src/mem_wb_reg.sv
`timescale 1ns/1ps

module mem_wb_reg (
	input logic CLK,
	input logic nRST,
	input datapath_mux_pkg::ex_mem_t ex_mem,
	input cpu_types_pkg::word_t load_data,
	input logic enable,
	input logic flush,
	output datapath_mux_pkg::mem_wb_t mem_wb
);
	import cpu_types_pkg::*;
	import datapath_mux_pkg::*;

	mem_wb_t wb_reg;
	mem_wb_t wb_nxt;

	// empty slot, register indices are passed in so flush can keep them
	function automatic mem_wb_t bubble(input regbits_t rt, input regbits_t rd);
		mem_wb_t b;
		b = '0;
		b.reg_dest = SEL_RD;
		b.mem_to_reg = SEL_RESULT;
		b.rt = rt;
		b.rd = rd;
		// tracker sees a nop rather than an all-zero funct
		b.trace.opcode = RTYPE;
		b.trace.funct = ADD;
		return b;
	endfunction

	assign mem_wb = wb_reg;

	always_comb begin : nxt_logic
		// hold by default, covers enable low
		wb_nxt = wb_reg;

		if (flush) begin
			// flush wins over enable
			wb_nxt = bubble(wb_reg.rt, wb_reg.rd);
		end else if (enable) begin
			wb_nxt.wen = ex_mem.wen;
			wb_nxt.halt = ex_mem.halt;
			wb_nxt.reg_dest = ex_mem.reg_dest;
			wb_nxt.mem_to_reg = ex_mem.mem_to_reg;
			wb_nxt.result = ex_mem.result;
			wb_nxt.mem_data = load_data;
			wb_nxt.rt = ex_mem.rt;
			wb_nxt.rd = ex_mem.rd;

			// tracker fields ride along unchanged
			wb_nxt.trace = ex_mem.trace;
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin : reg_logic
		if (!nRST) begin
			wb_reg <= bubble('0, '0);
		end else begin
			wb_reg <= wb_nxt;
		end
	end

endmodule

// File: src/reg_writeback.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module reg_writeback (
	input logic CLK,
	input logic nRST,
	input datapath_mux_pkg::mem_wb_t mem_wb,
	input cpu_types_pkg::regbits_t rsel1,
	input cpu_types_pkg::regbits_t rsel2,
	output cpu_types_pkg::word_t rdat1,
	output cpu_types_pkg::word_t rdat2
);
	import cpu_types_pkg::*;
	import datapath_mux_pkg::*;

	// jal links through the last register
	localparam regbits_t RA_IDX = regbits_t'(`REG_COUNT - 1);

	word_t regs [`REG_COUNT];
	regbits_t wsel;
	word_t wdat;
	logic wr_en;

	// destination register
	always_comb begin : dest_mux
		case (mem_wb.reg_dest)
			SEL_RT:  wsel = mem_wb.rt;
			SEL_RA:  wsel = RA_IDX;
			default: wsel = mem_wb.rd;
		endcase
	end

	// write data
	always_comb begin : data_mux
		case (mem_wb.mem_to_reg)
			SEL_MEMDATA: wdat = mem_wb.mem_data;
			SEL_NPC:     wdat = mem_wb.trace.next_pc;
			default:     wdat = mem_wb.result;
		endcase
	end

	// writes to r0 are dropped
	assign wr_en = mem_wb.wen && (wsel != '0);

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wsel] <= wdat;
		end
	end

	// no bypass, a write shows up after the edge
	assign rdat1 = (rsel1 == '0) ? '0 : regs[rsel1];
	assign rdat2 = (rsel2 == '0) ? '0 : regs[rsel2];

endmodule

// File: src/mem_wb_backend.sv
`timescale 1ns/1ps

module mem_wb_backend (
	input logic CLK,
	input logic nRST,
	input datapath_mux_pkg::ex_mem_t ex_mem,
	input logic enable,
	input logic flush,
	input cpu_types_pkg::regbits_t rsel1,
	input cpu_types_pkg::regbits_t rsel2,
	output cpu_types_pkg::word_t rdat1,
	output cpu_types_pkg::word_t rdat2,
	output logic halt,
	output datapath_mux_pkg::mem_wb_t wb
);
	import cpu_types_pkg::*;
	import datapath_mux_pkg::*;

	word_t load_data;
	mem_wb_t mem_wb;

	// alu result doubles as the byte address
	data_mem u_data_mem (
		.CLK        (CLK),
		.nRST       (nRST),
		.addr       (ex_mem.result),
		.store_data (ex_mem.store_data),
		.mem_write  (ex_mem.mem_write),
		.load_data  (load_data)
	);

	mem_wb_reg u_mem_wb_reg (
		.CLK       (CLK),
		.nRST      (nRST),
		.ex_mem    (ex_mem),
		.load_data (load_data),
		.enable    (enable),
		.flush     (flush),
		.mem_wb    (mem_wb)
	);

	reg_writeback u_reg_writeback (
		.CLK    (CLK),
		.nRST   (nRST),
		.mem_wb (mem_wb),
		.rsel1  (rsel1),
		.rsel2  (rsel2),
		.rdat1  (rdat1),
		.rdat2  (rdat2)
	);

	// halt leaves as soon as it reaches the stage register
	assign halt = mem_wb.halt;
	assign wb = mem_wb;

endmodule

// File: tb/mem_wb_backend_asserts.sv
`timescale 1ns/1ps

module mem_wb_backend_asserts (
	input logic CLK,
	input logic nRST,
	input logic enable,
	input logic flush,
	input datapath_mux_pkg::mem_wb_t mem_wb
);

	// a flushed slot neither writes nor halts
	property flush_clears;
		@(posedge CLK) disable iff (!nRST)
		flush |=> (!mem_wb.wen && !mem_wb.halt);
	endproperty

	// stall without flush keeps the whole entry
	property stall_holds;
		@(posedge CLK) disable iff (!nRST)
		(!enable && !flush) |=> $stable(mem_wb);
	endproperty

	property reset_no_write;
		@(posedge CLK) !nRST |-> !mem_wb.wen;
	endproperty

	a_flush_clears: assert property (flush_clears)
		else $error("wen or halt still set after a flush cycle");
	a_stall_holds: assert property (stall_holds)
		else $error("stage register changed while stalled");
	a_reset_no_write: assert property (reset_no_write)
		else $error("wen high during reset");

endmodule

bind mem_wb_reg mem_wb_backend_asserts u_mem_wb_asserts (
	.CLK    (CLK),
	.nRST   (nRST),
	.enable (enable),
	.flush  (flush),
	.mem_wb (mem_wb)
);

// File: tb/mem_wb_backend_tb.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module mem_wb_backend_tb;
	import cpu_types_pkg::*;
	import datapath_mux_pkg::*;

	logic CLK;
	logic nRST;
	ex_mem_t ex_mem;
	logic enable;
	logic flush;
	regbits_t rsel1;
	regbits_t rsel2;
	word_t rdat1;
	word_t rdat2;
	logic halt;
	mem_wb_t wb;

	// reference copies of data memory and register file
	word_t mem_model [`DMEM_WORDS];
	word_t reg_model [`REG_COUNT];
	int err_count;
	int check_count;
	int test_count;

	mem_wb_backend u_mem_wb_backend (.*);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	// inputs change 1 ns after the edge
	task automatic tick();
		@(posedge CLK);
		#1;
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		check_count++;
		if (act !== exp) begin
			err_count++;
			$display("FAIL %s expected %h got %h", name, exp, act);
		end
	endtask

	task automatic check_wb(input string name, input mem_wb_t exp, input mem_wb_t act);
		check_count++;
		if (act !== exp) begin
			err_count++;
			$display("FAIL %s expected %h got %h", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		check_count++;
		if (act !== exp) begin
			err_count++;
			$display("FAIL %s expected %h got %h", name, exp, act);
		end
	endtask

	function automatic int mem_index(input word_t addr);
		return (addr >> 2) % `DMEM_WORDS;
	endfunction

	function automatic ex_mem_t idle_bundle();
		ex_mem_t e;
		e = '0;
		e.reg_dest = SEL_RD;
		e.mem_to_reg = SEL_RESULT;
		e.trace.opcode = RTYPE;
		e.trace.funct = ADD;
		return e;
	endfunction

	function automatic ex_mem_t rand_bundle();
		ex_mem_t e;
		e = idle_bundle();
		e.wen = 1'b1;
		e.result = $urandom;
		e.store_data = $urandom;
		e.rt = regbits_t'($urandom);
		e.rd = regbits_t'($urandom);
		e.trace.pc = $urandom;
		e.trace.next_pc = e.trace.pc + 32'd4;
		e.trace.instruction = $urandom;
		return e;
	endfunction

	// empty slot keeping only the register indices
	function automatic mem_wb_t nop_entry(input regbits_t rt, input regbits_t rd);
		mem_wb_t b;
		b = '0;
		b.reg_dest = SEL_RD;
		b.mem_to_reg = SEL_RESULT;
		b.rt = rt;
		b.rd = rd;
		b.trace.opcode = RTYPE;
		b.trace.funct = ADD;
		return b;
	endfunction

	// load data is whatever the model holds before this bundle's store
	function automatic mem_wb_t expect_entry(input ex_mem_t e);
		mem_wb_t x;
		x.wen = e.wen;
		x.halt = e.halt;
		x.reg_dest = e.reg_dest;
		x.mem_to_reg = e.mem_to_reg;
		x.result = e.result;
		x.mem_data = mem_model[mem_index(e.result)];
		x.rt = e.rt;
		x.rd = e.rd;
		x.trace = e.trace;
		return x;
	endfunction

	task automatic read_reg(input regbits_t idx);
		rsel1 = idx;
		rsel2 = idx;
		#1;
		check_word($sformatf("rdat1[r%0d]", idx), reg_model[idx], rdat1);
		check_word($sformatf("rdat2[r%0d]", idx), reg_model[idx], rdat2);
	endtask

	// drive one bundle into the stage register and retire it
	task automatic issue(input ex_mem_t e);
		mem_wb_t exp;
		regbits_t dest;
		word_t wdat;
		exp = expect_entry(e);
		case (e.reg_dest)
			SEL_RT:  dest = e.rt;
			SEL_RA:  dest = regbits_t'(31);
			default: dest = e.rd;
		endcase
		case (e.mem_to_reg)
			SEL_MEMDATA: wdat = exp.mem_data;
			SEL_NPC:     wdat = e.trace.next_pc;
			default:     wdat = e.result;
		endcase
		ex_mem = e;
		tick();
		ex_mem = idle_bundle();
		if (e.mem_write)
			mem_model[mem_index(e.result)] = e.store_data;
		check_wb("wb", exp, wb);
		tick();
		if (e.wen && dest != '0)
			reg_model[dest] = wdat;
		read_reg(dest);
	endtask

	task automatic report(input string name, input int errs_before);
		test_count++;
		if (err_count == errs_before)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, err_count - errs_before);
	endtask

	task automatic reset_values();
		int e0;
		e0 = err_count;
		check_wb("wb", nop_entry('0, '0), wb);
		check_bit("halt", 1'b0, halt);
		for (int i = 0; i < `REG_COUNT; i++)
			read_reg(regbits_t'(i));
		report("reset", e0);
	endtask

	task automatic alu_writeback();
		ex_mem_t e;
		int e0;
		e0 = err_count;
		for (int i = 0; i < 9; i++) begin
			e = rand_bundle();
			e.reg_dest = (i % 3 == 1) ? SEL_RT : (i % 3 == 2) ? SEL_RA : SEL_RD;
			issue(e);
		end
		// r0 stays zero
		e = rand_bundle();
		e.rd = '0;
		issue(e);
		report("alu_writeback", e0);
	endtask

	task automatic store_then_load();
		ex_mem_t e;
		word_t addrs [4];
		int e0;
		e0 = err_count;
		foreach (addrs[i]) begin
			addrs[i] = $urandom;
			e = rand_bundle();
			e.wen = 1'b0;
			e.mem_write = 1'b1;
			e.result = addrs[i];
			e.trace.opcode = SW;
			issue(e);
		end
		foreach (addrs[i]) begin
			e = rand_bundle();
			e.mem_read = 1'b1;
			e.reg_dest = SEL_RT;
			e.mem_to_reg = SEL_MEMDATA;
			e.result = addrs[i];
			e.trace.opcode = LW;
			issue(e);
		end
		// jal links next_pc into r31
		e = rand_bundle();
		e.reg_dest = SEL_RA;
		e.mem_to_reg = SEL_NPC;
		e.trace.opcode = J;
		issue(e);
		report("store_load", e0);
	endtask

	task automatic stall_holds_entry();
		ex_mem_t e_old;
		ex_mem_t e_new;
		mem_wb_t exp_old;
		mem_wb_t exp_new;
		int e0;
		e0 = err_count;
		e_old = rand_bundle();
		e_old.rd = 5'd7;
		e_new = rand_bundle();
		e_new.rd = 5'd9;
		exp_old = expect_entry(e_old);
		exp_new = expect_entry(e_new);
		ex_mem = e_old;
		tick();
		check_wb("wb", exp_old, wb);
		reg_model[7] = e_old.result;
		enable = 1'b0;
		ex_mem = e_new;
		for (int i = 0; i < 3; i++) begin
			tick();
			check_wb("wb", exp_old, wb);
		end
		read_reg(5'd9);
		read_reg(5'd7);
		enable = 1'b1;
		tick();
		check_wb("wb", exp_new, wb);
		ex_mem = idle_bundle();
		tick();
		reg_model[9] = e_new.result;
		read_reg(5'd9);
		report("stall", e0);
	endtask

	task automatic flush_to_bubble();
		ex_mem_t e_prev;
		ex_mem_t e;
		int e0;
		e0 = err_count;
		e_prev = rand_bundle();
		e_prev.wen = 1'b0;
		e_prev.rt = 5'd4;
		e_prev.rd = 5'd3;
		ex_mem = e_prev;
		tick();
		check_wb("wb", expect_entry(e_prev), wb);
		e = rand_bundle();
		e.rd = 5'd12;
		flush = 1'b1;
		ex_mem = e;
		tick();
		flush = 1'b0;
		ex_mem = idle_bundle();
		check_wb("wb", nop_entry(e_prev.rt, e_prev.rd), wb);
		tick();
		read_reg(5'd12);
		report("flush", e0);
	endtask

	task automatic halt_then_flush();
		ex_mem_t e;
		int e0;
		e0 = err_count;
		e = idle_bundle();
		e.halt = 1'b1;
		e.trace.opcode = HALT;
		ex_mem = e;
		tick();
		// stall so the halted entry stays put
		enable = 1'b0;
		ex_mem = idle_bundle();
		// halt shows one edge after the bundle is taken
		check_bit("halt", 1'b1, halt);
		flush = 1'b1;
		tick();
		flush = 1'b0;
		enable = 1'b1;
		check_bit("halt", 1'b0, halt);
		check_bit("wb.wen", 1'b0, wb.wen);
		report("halt", e0);
	endtask

	initial begin
		void'($urandom(32'hf4a219b1));
		nRST = 1'b0;
		ex_mem = idle_bundle();
		enable = 1'b1;
		flush = 1'b0;
		rsel1 = '0;
		rsel2 = '0;
		err_count = 0;
		check_count = 0;
		test_count = 0;
		foreach (mem_model[i])
			mem_model[i] = '0;
		foreach (reg_model[i])
			reg_model[i] = '0;
		repeat (8) @(posedge CLK);
		#1;
		nRST = 1'b1;

		reset_values();
		alu_writeback();
		store_then_load();
		stall_holds_entry();
		flush_to_bubble();
		halt_then_flush();

		$display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
		if (err_count == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: filelist.f
+incdir+src
src/cpu_types_pkg.sv
src/datapath_mux_pkg.sv
src/data_mem.sv
src/mem_wb_reg.sv
src/reg_writeback.sv
src/mem_wb_backend.sv
tb/mem_wb_backend_asserts.sv
tb/mem_wb_backend_tb.sv
